//--- verilog/station_pkg.sv
package station_pkg;

    // 640x480 at 60 Hz, counts in pixel clocks
    localparam int H_DISPLAY = 640;
    localparam int H_FRONT   = 16;
    localparam int H_SYNC    = 96;
    localparam int H_BACK    = 48;
    localparam int H_TOTAL   = H_DISPLAY + H_FRONT + H_SYNC + H_BACK;

    // vertical, counts in lines
    localparam int V_DISPLAY = 480;
    localparam int V_BOTTOM  = 10;
    localparam int V_SYNC    = 2;
    localparam int V_TOP     = 33;
    localparam int V_TOTAL   = V_DISPLAY + V_BOTTOM + V_SYNC + V_TOP;

    // gamepad slot timing, 12 us and 6 us at 25 MHz
    localparam int PAD_BIT_CYCLES  = 300;
    localparam int PAD_HALF_CYCLES = 150;
    localparam int PAD_BUTTONS     = 8;

    typedef logic [9:0]  coord_t;      // pixel or line position
    typedef logic [10:0] pad_count_t;  // cycles within a slot
    typedef logic [2:0]  color_code_t;
    typedef logic [1:0]  channel_t;

    // fields in the order the pad shifts them out, pressed = 1
    typedef struct packed {
        logic a;
        logic b;
        logic select;
        logic start;
        logic up;
        logic down;
        logic left;
        logic right;
    } buttons_t;

    typedef struct packed {
        channel_t r;
        channel_t g;
        channel_t b;
    } rgb_t;

    typedef enum logic [1:0] {
        PAD_LATCH,
        PAD_FIRST,
        PAD_SHIFT
    } pad_state_t;

endpackage

//--- verilog/nes_pad_receiver.sv
`timescale 1ns/1ps

module nes_pad_receiver (
    input  logic                clk,
    input  logic                reset,
    input  logic                data,     // serial button data, low = pressed
    output logic                latch,
    output logic                nes_clk,
    output station_pkg::buttons_t buttons
);
    import station_pkg::*;

    pad_state_t state;
    pad_state_t state_nxt;
    pad_count_t count;
    pad_count_t count_nxt;
    logic [2:0] bit_idx;      // button currently on the data line
    logic [2:0] bit_idx_nxt;
    logic       sample;

    // slot sequencing: latch, half slot for A, then seven full slots
    always_comb begin
        state_nxt   = state;
        count_nxt   = count + 1'b1;
        bit_idx_nxt = bit_idx;
        case (state)
            PAD_LATCH: begin
                if (count == PAD_BIT_CYCLES) begin
                    state_nxt   = PAD_FIRST;
                    count_nxt   = '0;
                    bit_idx_nxt = '0;
                end
            end
            PAD_FIRST: begin
                if (count == PAD_HALF_CYCLES) begin
                    state_nxt   = PAD_SHIFT;
                    count_nxt   = '0;
                    bit_idx_nxt = 3'd1;
                end
            end
            PAD_SHIFT: begin
                if (count == PAD_BIT_CYCLES) begin
                    count_nxt = '0;
                    if (bit_idx == 3'(PAD_BUTTONS - 1)) begin
                        state_nxt = PAD_LATCH;  // poll done, start over
                    end else begin
                        bit_idx_nxt = bit_idx + 1'b1;
                    end
                end
            end
            default: begin
                state_nxt = PAD_LATCH;
                count_nxt = '0;
            end
        endcase
    end

    // A is valid right after latch falls, the rest mid slot
    assign sample = (state == PAD_FIRST && count == '0) ||
                    (state == PAD_SHIFT && count == PAD_HALF_CYCLES);

    // outputs follow the next state so they line up with state and count
    always_ff @(posedge clk) begin
        if (reset) begin
            // park at the end of the last slot, first edge opens a full latch
            state   <= PAD_SHIFT;
            count   <= pad_count_t'(PAD_BIT_CYCLES);
            bit_idx <= 3'(PAD_BUTTONS - 1);
            latch   <= 1'b0;
            nes_clk <= 1'b0;
        end else begin
            state   <= state_nxt;
            count   <= count_nxt;
            bit_idx <= bit_idx_nxt;
            latch   <= (state_nxt == PAD_LATCH);
            nes_clk <= (state_nxt == PAD_SHIFT) && (count_nxt <= PAD_HALF_CYCLES);
        end
    end

    // snapshot, one field per sample point
    always_ff @(posedge clk) begin
        if (reset) begin
            buttons <= '0;
        end else if (sample) begin
            buttons[~bit_idx] <= ~data;  // index 0 is a, the msb
        end
    end

endmodule

//--- verilog/vga_timing.sv
`timescale 1ns/1ps

module vga_timing (
    input  logic clk,
    input  logic reset,
    output logic hsync,     // active low
    output logic vsync,     // active low
    output logic video_on
);
    import station_pkg::*;

    coord_t h_count;
    coord_t v_count;
    logic   h_last;
    logic   v_last;
    logic   h_in_sync;
    logic   v_in_sync;

    assign h_last = (h_count == coord_t'(H_TOTAL - 1));
    assign v_last = (v_count == coord_t'(V_TOTAL - 1));

    // pixel counter, wraps every line
    always_ff @(posedge clk) begin
        if (reset) begin
            h_count <= '0;
        end else if (h_last) begin
            h_count <= '0;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // line counter, steps at end of each line
    always_ff @(posedge clk) begin
        if (reset) begin
            v_count <= '0;
        end else if (h_last) begin
            if (v_last) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 1'b1;
            end
        end
    end

    // sync windows after the front porch
    assign h_in_sync = (h_count >= H_DISPLAY + H_FRONT) &&
                       (h_count <  H_DISPLAY + H_FRONT + H_SYNC);
    assign v_in_sync = (v_count >= V_DISPLAY + V_BOTTOM) &&
                       (v_count <  V_DISPLAY + V_BOTTOM + V_SYNC);

    always_ff @(posedge clk) begin
        if (reset) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            hsync <= ~h_in_sync;  // one clock behind the count
            vsync <= ~v_in_sync;
        end
    end

    assign video_on = (h_count < H_DISPLAY) && (v_count < V_DISPLAY);

endmodule

//--- verilog/color_select.sv
`timescale 1ns/1ps

module color_select (
    input  logic                  clk,
    input  logic                  reset,
    input  station_pkg::buttons_t buttons,
    input  logic                  video_on,
    output station_pkg::rgb_t     rgb
);
    import station_pkg::*;

    color_code_t code;
    rgb_t        palette_rgb;

    // highest priority pressed button wins, nothing pressed keeps the colour
    always_ff @(posedge clk) begin
        if (reset) begin
            code <= 3'd0;
        end else if (buttons.up) begin
            code <= 3'd1;
        end else if (buttons.down) begin
            code <= 3'd2;
        end else if (buttons.left) begin
            code <= 3'd3;
        end else if (buttons.right) begin
            code <= 3'd4;
        end else if (buttons.a) begin
            code <= 3'd5;
        end else if (buttons.b) begin
            code <= 3'd6;
        end else if (buttons.start) begin
            code <= 3'd7;
        end else if (buttons.select) begin
            code <= 3'd0;  // select clears to black
        end
    end

    always_comb begin
        case (code)
            3'd1:    palette_rgb = '{r: 2'b11, g: 2'b00, b: 2'b00};  // red
            3'd2:    palette_rgb = '{r: 2'b00, g: 2'b11, b: 2'b00};  // green
            3'd3:    palette_rgb = '{r: 2'b00, g: 2'b00, b: 2'b11};  // blue
            3'd4:    palette_rgb = '{r: 2'b11, g: 2'b11, b: 2'b00};  // yellow
            3'd5:    palette_rgb = '{r: 2'b00, g: 2'b11, b: 2'b11};  // cyan
            3'd6:    palette_rgb = '{r: 2'b11, g: 2'b00, b: 2'b11};  // magenta
            3'd7:    palette_rgb = '{r: 2'b11, g: 2'b11, b: 2'b11};  // white
            default: palette_rgb = '0;
        endcase
    end

    // black outside the visible area
    always_ff @(posedge clk) begin
        if (reset) begin
            rgb <= '0;
        end else begin
            rgb <= video_on ? palette_rgb : '0;
        end
    end

endmodule

//--- verilog/tiny_station_top.sv
`timescale 1ns/1ps

module tiny_station_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              pad_data,
    output logic              pad_latch,
    output logic              pad_clk,
    output logic              hsync,
    output logic              vsync,
    output station_pkg::rgb_t rgb
);
    import station_pkg::*;

    buttons_t buttons;  // latest polled snapshot
    logic     video_on;

    nes_pad_receiver i_pad (
        .clk     (clk),
        .reset   (reset),
        .data    (pad_data),
        .latch   (pad_latch),
        .nes_clk (pad_clk),
        .buttons (buttons)
    );

    vga_timing i_timing (
        .clk      (clk),
        .reset    (reset),
        .hsync    (hsync),
        .vsync    (vsync),
        .video_on (video_on)
    );

    // colour follows the pad, blanked by the timing
    color_select i_color (
        .clk      (clk),
        .reset    (reset),
        .buttons  (buttons),
        .video_on (video_on),
        .rgb      (rgb)
    );

endmodule

//--- tests/nes_pad_model.sv
`timescale 1ns/1ps

module nes_pad_model (
    input  station_pkg::buttons_t mask,     // pressed = 1
    input  logic                  latch,
    input  logic                  nes_clk,
    output logic                  data      // low = pressed
);
    import station_pkg::*;

    logic [PAD_BUTTONS-1:0] shreg;  // a in the msb, shifted out first

    initial begin
        shreg = '0;
    end

    // buttons are captured when latch falls, each rising nes_clk moves to the next one
    always @(negedge latch or posedge nes_clk) begin
        if (nes_clk) begin
            shreg <= {shreg[PAD_BUTTONS-2:0], 1'b0};
        end else begin
            shreg <= mask;
        end
    end

    assign data = ~shreg[PAD_BUTTONS-1];

endmodule

//--- tests/tiny_station_tb.sv
`timescale 1ns/1ps

module tiny_station_tb;
    import station_pkg::*;

    localparam int POLL_CYCLES     = 2559;
    localparam int CYCLES_PER_TEST = 3 * POLL_CYCLES + 2 * H_TOTAL;

    logic     clk;
    logic     reset;
    logic     pad_data;
    logic     pad_latch;
    logic     pad_clk;
    logic     hsync;
    logic     vsync;
    rgb_t     rgb;
    buttons_t pad_mask;

    string    test_name[$];
    buttons_t test_mask[$];
    rgb_t     test_rgb[$];
    int       num_tests;
    bit       tests_loaded;
    int       passed;
    int       failed;
    int       monitor_errors;

    logic     hs_prev;      // hsync at the previous falling clock edge
    int       hs_falls;     // hsync falls seen since reset
    logic     latch_prev;
    logic     pclk_prev;
    int       latch_len;
    int       pclk_rises;
    bit       latch_seen;

    tiny_station_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .pad_data  (pad_data),
        .pad_latch (pad_latch),
        .pad_clk   (pad_clk),
        .hsync     (hsync),
        .vsync     (vsync),
        .rgb       (rgb)
    );

    nes_pad_model i_pad_model (
        .mask    (pad_mask),
        .latch   (pad_latch),
        .nes_clk (pad_clk),
        .data    (pad_data)
    );

    always #50 clk = ~clk;  // 100 ns period

    always @(negedge clk) begin
        if (reset) begin
            hs_falls <= 0;
        end else if (hs_prev && !hsync) begin
            hs_falls <= hs_falls + 1;
        end
        hs_prev <= hsync;
    end

    // blanking and gamepad protocol checked on every clock
    always @(negedge clk) begin
        if (reset) begin
            latch_len  <= 0;
            pclk_rises <= 0;
            latch_seen <= 1'b0;
        end else begin
            if ((!hsync || !vsync) && rgb != '0) begin
                $display("Fail blanking expected rgb 00 actual %h at %0t", rgb, $time);
                monitor_errors++;
            end
            if (latch_prev && !pad_latch) begin
                if (latch_len != PAD_BIT_CYCLES + 1) begin
                    $display("Fail latch_pulse expected %0d clocks actual %0d at %0t",
                             PAD_BIT_CYCLES + 1, latch_len, $time);
                    monitor_errors++;
                end
                latch_len <= 0;
            end else if (pad_latch) begin
                latch_len <= latch_len + 1;
            end
            if (!latch_prev && pad_latch) begin
                if (latch_seen && pclk_rises != PAD_BUTTONS - 1) begin
                    $display("Fail pad_clock_pulses expected %0d actual %0d at %0t",
                             PAD_BUTTONS - 1, pclk_rises, $time);
                    monitor_errors++;
                end
                pclk_rises <= 0;
                latch_seen <= 1'b1;
            end else if (!pclk_prev && pad_clk) begin
                pclk_rises <= pclk_rises + 1;
            end
        end
        latch_prev <= pad_latch;
        pclk_prev  <= pad_clk;
    end

    task automatic load_tests(output bit ok);
        int         fd;
        int         n;
        string      line;
        string      name;
        logic [7:0] mask;
        logic [5:0] expected;
        ok = 1'b0;
        fd = $fopen("tests/station_tests.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin  // skip the column notes
                    if ($sscanf(line, "%s %h %h", name, mask, expected) == 3) begin
                        test_name.push_back(name);
                        test_mask.push_back(buttons_t'(mask));
                        test_rgb.push_back(rgb_t'(expected));
                    end
                end
            end
            $fclose(fd);
            ok = (test_name.size() > 0);
        end
    endtask

    task automatic check_reset_state();
        if (rgb != '0 || !hsync || !vsync) begin
            $display("Fail reset_state expected rgb/hsync/vsync 00/1/1 actual %h/%b/%b",
                     rgb, hsync, vsync);
            monitor_errors++;
        end
    endtask

    // stop on an hsync fall whose following line has visible pixels
    task automatic wait_visible_line();
        bit found;
        found = 1'b0;
        while (!found) begin
            @(negedge clk);
            if (hs_prev && !hsync && (hs_falls + 1) % V_TOTAL < V_DISPLAY) begin
                found = 1'b1;
            end
        end
    endtask

    task automatic measure_line(input rgb_t expected, output int hits, output int wrong,
                                output rgb_t bad, output int period, output int width,
                                output int vs_low);
        bit done;
        hits   = 0;
        wrong  = 0;
        bad    = '0;
        period = 0;
        width  = 0;
        vs_low = 0;
        done   = 1'b0;
        while (!done) begin
            if (rgb == expected) begin
                hits++;
            end else if (rgb != '0) begin
                wrong++;
                bad = rgb;
            end
            if (!hsync) begin
                width++;
            end
            if (!vsync) begin
                vs_low++;  // visible lines lie outside the vsync pulse
            end
            @(negedge clk);
            period++;
            if (hs_prev && !hsync) begin
                done = 1'b1;  // next line starts here
            end
        end
    endtask

    task automatic run_test(input int idx);
        int          hits;
        int          wrong;
        int          period;
        int          width;
        int          vs_low;
        rgb_t        bad;
        int unsigned gap;
        gap = $urandom_range(50, 0);
        repeat (gap) @(negedge clk);
        pad_mask = test_mask[idx];
        @(negedge pad_latch);  // pad takes the new mask
        @(posedge pad_latch);  // that poll is complete
        repeat (2) @(negedge clk);
        wait_visible_line();
        measure_line(test_rgb[idx], hits, wrong, bad, period, width, vs_low);
        if (wrong != 0) begin
            $display("Fail %s expected rgb %h actual %h", test_name[idx], test_rgb[idx], bad);
            failed++;
        end else if (hits == 0) begin
            $display("Error: test %s never showed its colour in a visible line",
                     test_name[idx]);
            failed++;
        end else if (period != H_TOTAL) begin
            $display("Fail %s expected hsync period %0d actual %0d",
                     test_name[idx], H_TOTAL, period);
            failed++;
        end else if (width != H_SYNC) begin
            $display("Fail %s expected hsync width %0d actual %0d",
                     test_name[idx], H_SYNC, width);
            failed++;
        end else if (vs_low != 0) begin
            $display("Fail %s expected vsync low clocks 0 actual %0d", test_name[idx], vs_low);
            failed++;
        end else begin
            $display("Pass %s rgb %h", test_name[idx], test_rgb[idx]);
            passed++;
        end
    endtask

    initial begin
        bit          ok;
        int unsigned seed;
        clk            = 1'b0;
        reset          = 1'b1;
        pad_mask       = '0;
        passed         = 0;
        failed         = 0;
        monitor_errors = 0;
        tests_loaded   = 1'b0;
        seed = $urandom(32'hd8d2_d7f3);
        load_tests(ok);
        num_tests    = test_name.size();
        tests_loaded = 1'b1;
        if (!ok) begin
            $display("Error: no tests could be read from tests/station_tests.txt");
            $display("Testbench failed");
            $finish;
        end else begin
            repeat (10) begin
                @(negedge clk);
                check_reset_state();
            end
            reset = 1'b0;
            @(negedge clk);
            check_reset_state();
            for (int i = 0; i < num_tests; i++) begin
                run_test(i);
            end
            $display("%0d tests, %0d passed, %0d failed, %0d monitor errors",
                     num_tests, passed, failed, monitor_errors);
            if (failed == 0 && monitor_errors == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

    // watchdog budget scales with the number of tests
    initial begin
        wait (tests_loaded);
        repeat (num_tests * CYCLES_PER_TEST + 10000) @(posedge clk);
        $display("Error: timeout, the tests did not finish in time");
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- tests/station_tests.txt
# name, pressed mask in hex (bits a b select start up down left right), expected rgb in hex (rrggbb)
# a hold line expects the colour of the line before it
up 08 30
down 04 0c
left 02 03
right 01 3c
a 80 0f
b 40 33
start 10 3f
select 20 00
down_over_right 05 0c
up_over_a 88 30
hold_none 00 30
b_over_select 60 33

//--- filelist.f
verilog/station_pkg.sv
verilog/nes_pad_receiver.sv
verilog/vga_timing.sv
verilog/color_select.sv
verilog/tiny_station_top.sv
tests/nes_pad_model.sv
tests/tiny_station_tb.sv

//--- Bender.yml
package:
  name: tiny_station

sources:
  - verilog/station_pkg.sv
  - verilog/nes_pad_receiver.sv
  - verilog/vga_timing.sv
  - verilog/color_select.sv
  - verilog/tiny_station_top.sv
  - target: test
    files:
      - tests/nes_pad_model.sv
      - tests/tiny_station_tb.sv
